// ==== flist.f ====
src/conv2d_rmem_pkg.sv
src/rd_arbiter.sv
src/beat_unpacker.sv
src/weight_fetch.sv
src/pixel_fetch.sv
src/pixel_fifo.sv
src/conv2d_rmem.sv
sim/tb_mem_model.sv
sim/tb_conv2d_rmem.sv

// ==== sim/tb_conv2d_rmem.sv ====
// Convolution read engine testbench
module tb_conv2d_rmem import conv2d_rmem_pkg::*; ();

    localparam int CLK_PERIOD  = 40;
    localparam int KS          = 3;
    localparam int KN          = KS * KS;
    localparam int FIFO_DEPTH  = 64;
    localparam int TOTAL_WORDS = 20 + 37 + 150 + 16 + 24 + 32 + 64 + 8;

    logic              clk;
    logic              rst;
    rd_req_t           mem_req;
    logic              mem_req_valid;
    logic              mem_req_ready;
    rd_beat_t          mem_beat;
    logic              mem_beat_valid;
    logic              mem_beat_ready;
    logic              w_start;
    word_t             w_addr;
    logic [CNT_W-1:0]  w_count;
    logic              x_start;
    word_t             x_addr;
    logic [CNT_W-1:0]  x_length;
    logic              kernel_load;
    logic              w_busy;
    logic              x_busy;
    word_t [KN-1:0]    pxl_w;
    logic              kernel_valid;
    word_t             pxl_x;
    logic              pxl_valid;
    logic              pxl_ready;

    int                checks;
    int                errors;
    logic [31:0]       seed;

    conv2d_rmem #(
        .KS         (KS),
        .WRAM_DEPTH (256),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_dut (.*);

    tb_mem_model i_mem (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TOTAL_WORDS * 40 * CLK_PERIOD);
        $display("watchdog expired before the tests finished");
        $display("Simulation FAILED");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Memory content at a byte address
    function automatic word_t model_word(input word_t a);
        return (a >> 2) ^ 32'h3c00_0000;
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_kernel(input string name, input word_t [KN-1:0] got,
                                input word_t [KN-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic note_failure(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    task automatic start_stream(input word_t addr, input int len);
        @(negedge clk);
        x_addr   = addr;
        x_length = CNT_W'(len);
        x_start  = 1'b1;
        @(negedge clk);
        x_start = 1'b0;
    endtask

    task automatic start_both(input word_t wa, input int wc, input word_t xa, input int xl);
        @(negedge clk);
        w_addr   = wa;
        w_count  = CNT_W'(wc);
        w_start  = 1'b1;
        x_addr   = xa;
        x_length = CNT_W'(xl);
        x_start  = 1'b1;
        @(negedge clk);
        w_start = 1'b0;
        x_start = 1'b0;
    endtask

    task automatic wait_weights_idle();
        int n;
        n = 0;
        while (w_busy && n < 4000) begin
            @(negedge clk);
            n++;
        end
        if (w_busy)
            note_failure("w_busy never fell after the weight prefetch");
    endtask

    // Pops words on the falling edge, the FIFO moves on at the next rising edge
    task automatic collect_pixels(input word_t base, input int n, input logic random_ready);
        int got;
        int idle;
        got  = 0;
        idle = 0;
        while (got < n && idle < 40 * BURST_WORDS) begin
            @(negedge clk);
            seed      = xorshift32(seed);
            pxl_ready = random_ready ? seed[0] : 1'b1;
            if (pxl_valid && pxl_ready) begin
                check_word("pxl_x", pxl_x, model_word(base + word_t'(4 * got)));
                got++;
                idle = 0;
            end else begin
                idle++;
            end
        end
        if (got < n)
            note_failure($sformatf("pixel stream stopped after %0d of %0d words", got, n));
        @(negedge clk);
        pxl_ready = 1'b1;
    endtask

    task automatic load_and_check_kernel(input word_t base);
        word_t [KN-1:0] exp;
        for (int i = 0; i < KN; i++)
            exp[i] = model_word(base + word_t'(4 * i));
        @(negedge clk);
        kernel_load = 1'b1;
        @(negedge clk);
        kernel_load = 1'b0;
        check_flag("kernel_valid", kernel_valid, 1'b0);
        repeat (KN) @(negedge clk);
        check_flag("kernel_valid", kernel_valid, 1'b0);    // One cycle early
        @(negedge clk);
        check_flag("kernel_valid", kernel_valid, 1'b1);
        check_kernel("pxl_w", pxl_w, exp);
    endtask

    task automatic test_kernel_load();
        start_both(32'h100, 20, 32'h0, 0);
        wait_weights_idle();
        load_and_check_kernel(32'h100);
    endtask

    task automatic test_short_stream();
        logic extra;
        extra = 1'b0;
        start_stream(32'h400, 37);
        collect_pixels(32'h400, 37, 1'b0);
        check_flag("x_busy", x_busy, 1'b0);
        repeat (40) begin
            @(negedge clk);
            if (pxl_valid)
                extra = 1'b1;
        end
        check_flag("pxl_valid", extra, 1'b0);
    endtask

    task automatic test_backpressure();
        start_stream(32'h2000, 150);
        collect_pixels(32'h2000, 150, 1'b1);
        check_flag("x_busy", x_busy, 1'b0);
    endtask

    task automatic test_concurrent();
        start_both(32'h800, 16, 32'h1000, 24);
        collect_pixels(32'h1000, 24, 1'b0);
        wait_weights_idle();
        load_and_check_kernel(32'h800);
    endtask

    task automatic test_reset_mid_stream();
        start_both(32'h1800, 32, 32'h3000, 64);
        collect_pixels(32'h3000, 10, 1'b0);
        @(negedge clk);
        rst = 1'b1;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        check_flag("w_busy", w_busy, 1'b0);
        check_flag("x_busy", x_busy, 1'b0);
        check_flag("pxl_valid", pxl_valid, 1'b0);
        check_flag("kernel_valid", kernel_valid, 1'b0);
        check_flag("mem_req_valid", mem_req_valid, 1'b0);
        start_stream(32'h5000, 8);
        collect_pixels(32'h5000, 8, 1'b0);
    endtask

    initial begin
        checks      = 0;
        errors      = 0;
        seed        = 32'hf7c7ca41;
        rst         = 1'b1;
        w_start     = 1'b0;
        w_addr      = '0;
        w_count     = '0;
        x_start     = 1'b0;
        x_addr      = '0;
        x_length    = '0;
        kernel_load = 1'b0;
        pxl_ready   = 1'b0;
        repeat (2) @(negedge clk);
        rst = 1'b0;

        test_kernel_load();
        test_short_stream();
        test_backpressure();
        test_concurrent();
        test_reset_mid_stream();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

// ==== sim/tb_mem_model.sv ====
// Burst memory model
module tb_mem_model import conv2d_rmem_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  rd_req_t  mem_req,
    input  logic     mem_req_valid,
    output logic     mem_req_ready,
    output rd_beat_t mem_beat,
    output logic     mem_beat_valid,
    input  logic     mem_beat_ready
);

    logic [31:0]       seed;
    logic              req_fire;
    logic              beat_fire;
    logic [ADDR_W-1:0] req_addr;
    logic [ADDR_W-1:0] base;        // Start address of the open burst
    logic              busy;
    int                beat_idx;
    int                gap;         // Idle cycles before the next beat

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic word_t mem_word(input logic [ADDR_W-1:0] a);
        return word_t'(a >> 2) ^ 32'h3c00_0000;
    endfunction

    function automatic rd_beat_t make_beat(input logic [ADDR_W-1:0] a, input logic last);
        rd_beat_t b;
        b.last = last;
        for (int k = 0; k < WORDS_PER_BEAT; k++)
            b.data[k*WORD_W +: WORD_W] = mem_word(a + ADDR_W'(4 * k));
        return b;
    endfunction

    initial begin
        seed           = 32'hf7c7ca41;
        busy           = 1'b0;
        beat_idx       = 0;
        gap            = 0;
        mem_req_ready  = 1'b0;
        mem_beat_valid = 1'b0;
        mem_beat       = '0;
    end

    // Handshakes as seen by the DUT at the rising edge
    always @(posedge clk) begin
        req_fire  = mem_req_valid && mem_req_ready;
        beat_fire = mem_beat_valid && mem_beat_ready;
        req_addr  = mem_req.addr;
    end

    always @(negedge clk or posedge rst) begin
        if (rst) begin
            busy           = 1'b0;
            beat_idx       = 0;
            gap            = 0;
            mem_req_ready  = 1'b0;
            mem_beat_valid = 1'b0;
        end else begin
            if (beat_fire) begin
                mem_beat_valid = 1'b0;
                if (beat_idx == BURST_BEATS - 1) begin
                    busy = 1'b0;
                end else begin
                    beat_idx = beat_idx + 1;
                    seed     = xorshift32(seed);
                    gap      = seed % 3;
                end
            end
            if (req_fire) begin
                busy     = 1'b1;
                base     = req_addr;
                beat_idx = 0;
                seed     = xorshift32(seed);
                gap      = seed % 6;        // Read latency
            end
            if (busy && !mem_beat_valid) begin
                if (gap == 0) begin
                    mem_beat       = make_beat(base + ADDR_W'(beat_idx * (BEAT_W / 8)),
                                               beat_idx == BURST_BEATS - 1);
                    mem_beat_valid = 1'b1;
                end else begin
                    gap = gap - 1;
                end
            end
            seed          = xorshift32(seed);
            mem_req_ready = !busy && seed[0];
        end
    end

endmodule

// ==== src/beat_unpacker.sv ====
// Beat to word unpacker
module beat_unpacker import conv2d_rmem_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  rd_beat_t     beat_in,
    input  logic         beat_in_valid,
    output logic         beat_in_ready,
    input  owner_e       beat_owner,
    output tagged_word_t word,
    output logic         word_valid,
    input  logic         w_word_ready,
    input  logic         p_word_ready
);

    localparam int LEFT_W = $clog2(WORDS_PER_BEAT + 1);

    logic [BEAT_W-1:0] data_q;
    logic              last_q;
    owner_e            owner_q;
    logic [LEFT_W-1:0] left;         // Words still held in data_q
    logic              word_ready;
    logic              word_take;
    logic              beat_take;

    assign word_ready = (owner_q == OWN_W) ? w_word_ready : p_word_ready;
    assign word_valid = (left != '0);
    assign word_take  = word_valid && word_ready;

    // Next beat may load in the cycle the fourth word leaves
    assign beat_in_ready = (left == '0) || (left == LEFT_W'(1) && word_ready);
    assign beat_take     = beat_in_valid && beat_in_ready;

    assign word.data  = data_q[WORD_W-1:0];    // Lowest word first
    assign word.owner = owner_q;
    assign word.last  = last_q && (left == LEFT_W'(1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            left <= '0;
        else if (beat_take)
            left <= LEFT_W'(WORDS_PER_BEAT);
        else if (word_take)
            left <= left - LEFT_W'(1);
    end

    always_ff @(posedge clk) begin
        if (beat_take) begin
            data_q  <= beat_in.data;
            last_q  <= beat_in.last;
            owner_q <= beat_owner;
        end else if (word_take) begin
            data_q <= data_q >> WORD_W;
        end
    end

    // A stalled beat is held until it is taken
    a_beat_held: assert property (@(posedge clk) disable iff (rst)
        beat_in_valid && !beat_in_ready |=> beat_in_valid && $stable(beat_in));

endmodule

// ==== src/conv2d_rmem.sv ====
// Convolution read engine top
module conv2d_rmem import conv2d_rmem_pkg::*; #(
    parameter int KS         = 3,
    parameter int WRAM_DEPTH = 256,
    parameter int FIFO_DEPTH = 64
) (
    input  logic              clk,
    input  logic              rst,
    output rd_req_t           mem_req,
    output logic              mem_req_valid,
    input  logic              mem_req_ready,
    input  rd_beat_t          mem_beat,
    input  logic              mem_beat_valid,
    output logic              mem_beat_ready,
    input  logic              w_start,
    input  word_t             w_addr,
    input  logic [CNT_W-1:0]  w_count,
    input  logic              x_start,
    input  word_t             x_addr,
    input  logic [CNT_W-1:0]  x_length,
    input  logic              kernel_load,
    output logic              w_busy,
    output logic              x_busy,
    output word_t [KS*KS-1:0] pxl_w,
    output logic              kernel_valid,
    output word_t             pxl_x,
    output logic              pxl_valid,
    input  logic              pxl_ready
);

    rd_req_t                           w_req;
    logic                              w_req_valid;
    logic                              w_req_ready;
    rd_req_t                           p_req;
    logic                              p_req_valid;
    logic                              p_req_ready;
    rd_beat_t                          beat_in;
    logic                              beat_in_valid;
    logic                              beat_in_ready;
    owner_e                            beat_owner;
    tagged_word_t                      word;
    logic                              word_valid;
    logic                              w_word_ready;
    logic                              p_word_ready;
    logic                              fifo_push;
    word_t                             fifo_data;
    logic [$clog2(FIFO_DEPTH+1)-1:0]   fifo_free;

    rd_arbiter i_arbiter (.*);

    beat_unpacker i_unpacker (.*);

    weight_fetch #(
        .KS         (KS),
        .WRAM_DEPTH (WRAM_DEPTH)
    ) i_weight_fetch (.*);

    pixel_fetch #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_pixel_fetch (.*);

    pixel_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_pixel_fifo (.*);

endmodule

// ==== src/conv2d_rmem_pkg.sv ====
// Convolution read engine definitions
package conv2d_rmem_pkg;

    localparam int ADDR_W         = 32;    // Byte address
    localparam int BEAT_W         = 128;   // Memory beat
    localparam int WORD_W         = 32;    // Pixel or weight word
    localparam int WORDS_PER_BEAT = BEAT_W / WORD_W;
    localparam int BURST_BEATS    = 2;
    localparam int BURST_WORDS    = BURST_BEATS * WORDS_PER_BEAT;
    localparam int BURST_BYTES    = BURST_WORDS * (WORD_W / 8);
    localparam int CNT_W          = 18;    // Word count fields

    typedef logic [WORD_W-1:0] word_t;

    // Fetcher that owns a burst or a word
    typedef enum logic {
        OWN_W = 1'b0,
        OWN_P = 1'b1
    } owner_e;

    // Burst length is fixed at BURST_BEATS
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
    } rd_req_t;

    typedef struct packed {
        logic              last;    // Final beat of a burst
        logic [BEAT_W-1:0] data;
    } rd_beat_t;

    typedef struct packed {
        logic   last;               // Final word of a burst
        owner_e owner;
        word_t  data;
    } tagged_word_t;

endpackage

// ==== src/pixel_fetch.sv ====
// Pixel burst sequencer
module pixel_fetch import conv2d_rmem_pkg::*; #(
    parameter int FIFO_DEPTH = 64
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              x_start,
    input  word_t                             x_addr,
    input  logic [CNT_W-1:0]                  x_length,
    output rd_req_t                           p_req,
    output logic                              p_req_valid,
    input  logic                              p_req_ready,
    input  tagged_word_t                      word,
    input  logic                              word_valid,
    output logic                              p_word_ready,
    output logic                              fifo_push,
    output word_t                             fifo_data,
    input  logic [$clog2(FIFO_DEPTH+1)-1:0]   fifo_free,
    output logic                              x_busy
);

    localparam int FREE_W = $clog2(FIFO_DEPTH + 1);
    localparam int BCNT_W = CNT_W - 2;

    word_t             addr;
    logic [BCNT_W-1:0] bursts_left;
    logic [CNT_W-1:0]  length_q;
    logic [CNT_W-1:0]  pushed;
    logic [FREE_W-1:0] inflight;        // Words granted but not yet taken
    logic [FREE_W-1:0] skip;            // Leftovers of the previous stream
    logic [CNT_W:0]    len_round;
    logic              space_ok;
    logic              take;
    logic              keep;
    logic              grant;
    logic              start;

    assign len_round = {1'b0, x_length} + (CNT_W + 1)'(BURST_WORDS - 1);
    assign space_ok  = {1'b0, fifo_free} >= {1'b0, inflight} + (FREE_W + 1)'(BURST_WORDS);

    assign p_word_ready = 1'b1;     // FIFO space is reserved at grant
    assign take         = word_valid && (word.owner == OWN_P);
    assign keep         = take && (skip == '0) && (pushed != length_q);
    assign p_req_valid  = (bursts_left != '0) && space_ok;
    assign p_req.addr   = addr;
    assign grant        = p_req_valid && p_req_ready;
    assign start        = x_start && !x_busy;

    assign fifo_push = keep;
    assign fifo_data = word.data;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            x_busy      <= 1'b0;
            bursts_left <= '0;
            length_q    <= '0;
            pushed      <= '0;
            inflight    <= '0;
            skip        <= '0;
        end else begin
            inflight <= inflight + (grant ? FREE_W'(BURST_WORDS) : '0) - FREE_W'(take);
            if (start) begin
                x_busy      <= (x_length != '0);
                bursts_left <= len_round[CNT_W:3];
                length_q    <= x_length;
                pushed      <= '0;
                skip        <= inflight - FREE_W'(take);
            end else begin
                if (grant)
                    bursts_left <= bursts_left - BCNT_W'(1);
                if (take && skip != '0)
                    skip <= skip - FREE_W'(1);
                if (keep) begin
                    pushed <= pushed + CNT_W'(1);
                    if (pushed + CNT_W'(1) == length_q)
                        x_busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start)
            addr <= x_addr;
        else if (grant)
            addr <= addr + ADDR_W'(BURST_BYTES);
    end

endmodule

// ==== src/pixel_fifo.sv ====
// Show-ahead pixel FIFO
module pixel_fifo import conv2d_rmem_pkg::*; #(
    parameter int FIFO_DEPTH = 64
) (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              fifo_push,
    input  word_t                             fifo_data,
    output logic [$clog2(FIFO_DEPTH+1)-1:0]   fifo_free,
    output word_t                             pxl_x,
    output logic                              pxl_valid,
    input  logic                              pxl_ready
);

    localparam int PTR_W  = $clog2(FIFO_DEPTH);
    localparam int FREE_W = $clog2(FIFO_DEPTH + 1);

    word_t             mem [FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [FREE_W-1:0] count;
    logic              pop;

    assign pxl_x     = mem[rd_ptr];     // Head word shown ahead of the pop
    assign pxl_valid = (count != '0);
    assign pop       = pxl_valid && pxl_ready;
    assign fifo_free = FREE_W'(FIFO_DEPTH) - count;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (fifo_push)
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
            count <= count + FREE_W'(fifo_push) - FREE_W'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_push)
            mem[wr_ptr] <= fifo_data;
    end

    // Burst throttling upstream keeps the FIFO from filling
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        fifo_push |-> (count < FREE_W'(FIFO_DEPTH)));

endmodule

// ==== src/rd_arbiter.sv ====
// Burst read arbiter
module rd_arbiter import conv2d_rmem_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  rd_req_t  w_req,
    input  logic     w_req_valid,
    output logic     w_req_ready,
    input  rd_req_t  p_req,
    input  logic     p_req_valid,
    output logic     p_req_ready,
    output rd_req_t  mem_req,
    output logic     mem_req_valid,
    input  logic     mem_req_ready,
    input  rd_beat_t mem_beat,
    input  logic     mem_beat_valid,
    output logic     mem_beat_ready,
    output rd_beat_t beat_in,
    output logic     beat_in_valid,
    input  logic     beat_in_ready,
    output owner_e   beat_owner
);

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_REQ,
        ARB_RECV
    } arb_state_e;

    arb_state_e state;
    owner_e     owner;          // Owner of the current or most recent burst
    rd_req_t    req_q;
    logic       pick_p;
    logic       beat_done;

    // Pixel wins when alone, or when both ask and weight went last
    assign pick_p = p_req_valid && (!w_req_valid || owner == OWN_W);

    assign w_req_ready = (state == ARB_IDLE) && !pick_p;
    assign p_req_ready = (state == ARB_IDLE) && pick_p;

    assign mem_req        = req_q;
    assign mem_req_valid  = (state == ARB_REQ);
    assign mem_beat_ready = (state == ARB_RECV) && beat_in_ready;
    assign beat_in        = mem_beat;
    assign beat_in_valid  = (state == ARB_RECV) && mem_beat_valid;
    assign beat_owner     = owner;
    assign beat_done      = mem_beat_valid && mem_beat_ready && mem_beat.last;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ARB_IDLE;
            owner <= OWN_P;     // Weight goes first after reset
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (w_req_valid || p_req_valid) begin
                        state <= ARB_REQ;
                        owner <= pick_p ? OWN_P : OWN_W;
                    end
                end
                ARB_REQ: begin
                    if (mem_req_ready)
                        state <= ARB_RECV;
                end
                ARB_RECV: begin
                    if (beat_done)
                        state <= ARB_IDLE;
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ARB_IDLE)
            req_q <= pick_p ? p_req : w_req;
    end

    a_req_stable: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req));

    // Memory returns beats only for the open burst
    a_beat_in_burst: assert property (@(posedge clk) disable iff (rst)
        mem_beat_valid |-> state == ARB_RECV);

endmodule

// ==== src/weight_fetch.sv ====
// Weight prefetch and kernel loader
module weight_fetch import conv2d_rmem_pkg::*; #(
    parameter int KS         = 3,
    parameter int WRAM_DEPTH = 256
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               w_start,
    input  word_t              w_addr,
    input  logic [CNT_W-1:0]   w_count,
    output rd_req_t            w_req,
    output logic               w_req_valid,
    input  logic               w_req_ready,
    input  tagged_word_t       word,
    input  logic               word_valid,
    output logic               w_word_ready,
    input  logic               kernel_load,
    output logic               w_busy,
    output logic               kernel_valid,
    output word_t [KS*KS-1:0]  pxl_w
);

    localparam int KN     = KS * KS;
    localparam int WA_W   = $clog2(WRAM_DEPTH);
    localparam int RC_W   = $clog2(KN + 1);
    localparam int BCNT_W = CNT_W - 2;

    word_t             wram [WRAM_DEPTH];
    word_t             addr;
    logic [BCNT_W-1:0] bursts_left;
    logic [1:0]        open_bursts;     // Granted, last word not yet seen
    logic [CNT_W-1:0]  words_left;
    logic [WA_W-1:0]   wr_addr;
    logic [WA_W-1:0]   rd_addr;
    logic [RC_W-1:0]   rd_cnt;
    logic              shift_en;
    word_t             rd_data;
    logic [CNT_W:0]    count_round;
    logic              take;
    logic              grant;
    logic              wr_en;

    assign count_round  = {1'b0, w_count} + (CNT_W + 1)'(BURST_WORDS - 1);
    assign w_word_ready = 1'b1;
    assign take         = word_valid && (word.owner == OWN_W);
    assign wr_en        = take && (words_left != '0);
    assign w_req_valid  = (bursts_left != '0);
    assign w_req.addr   = addr;
    assign grant        = w_req_valid && w_req_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            w_busy      <= 1'b0;
            bursts_left <= '0;
            open_bursts <= '0;
            words_left  <= '0;
            wr_addr     <= '0;
        end else begin
            if (w_start && !w_busy) begin
                w_busy      <= (w_count != '0);
                bursts_left <= count_round[CNT_W:3];
                words_left  <= w_count;
                wr_addr     <= '0;
            end else begin
                if (grant)
                    bursts_left <= bursts_left - BCNT_W'(1);
                if (wr_en) begin
                    words_left <= words_left - CNT_W'(1);
                    wr_addr    <= wr_addr + WA_W'(1);
                end
                if (take && word.last && bursts_left == '0 && open_bursts == 2'd1)
                    w_busy <= 1'b0;
            end
            open_bursts <= open_bursts + {1'b0, grant} - {1'b0, take && word.last};
        end
    end

    always_ff @(posedge clk) begin
        if (w_start && !w_busy)
            addr <= w_addr;
        else if (grant)
            addr <= addr + ADDR_W'(BURST_BYTES);
        if (wr_en)
            wram[wr_addr] <= word.data;
        rd_data <= wram[rd_addr];
    end

    // Kernel load reads KN words, then shifts them in one cycle later
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_cnt       <= '0;
            rd_addr      <= '0;
            shift_en     <= 1'b0;
            kernel_valid <= 1'b0;
        end else begin
            shift_en <= (rd_cnt != '0);
            if (kernel_load && !w_busy) begin
                rd_cnt       <= RC_W'(KN);
                rd_addr      <= '0;
                kernel_valid <= 1'b0;
            end else if (rd_cnt != '0) begin
                rd_cnt  <= rd_cnt - RC_W'(1);
                rd_addr <= rd_addr + WA_W'(1);
            end
            if (shift_en && rd_cnt == '0)
                kernel_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (shift_en) begin
            for (int i = 0; i < KN - 1; i++)
                pxl_w[i] <= pxl_w[i+1];
            pxl_w[KN-1] <= rd_data;    // Word 0 ends up lowest
        end
    end

    a_load_idle: assert property (@(posedge clk) disable iff (rst)
        kernel_load |-> !w_busy);

endmodule
